// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = rv32i_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb.f
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_decoder.sv
verilog/rv_execute.sv
verilog/rv_reg_file.sv
verilog/rv_data_mem.sv
verilog/rv_imem_loader.sv
verilog/rv32i_core.sv
tb/tb_clock_gen.sv
tb/rv32i_chk.sv
tb/rv32i_tb.sv

// File: tb/rv32i_chk.sv
module rv32i_chk (
    input logic clk_i,
    input logic arst_n_i,
    input logic load_req_i,
    input logic load_ack_i,
    input logic store_valid_i,
    input logic store_en_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // ack only answers a pending request
    ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(load_ack_i) |-> $past(load_req_i))
        else $error("load_ack_o rose without a request");

    // ack holds until the host has let go of req
    ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(load_ack_i) |-> !$past(load_req_i))
        else $error("load_ack_o fell while the request was still high");

    // two valid cycles in a row need two stores in a row
    store_valid_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (store_valid_i && $past(store_valid_i)) |-> ($past(store_en_i) && $past(store_en_i, 2)))
        else $error("store_valid_o stayed high without back to back stores");

endmodule

bind rv32i_core rv32i_chk i_chk (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .load_req_i    (load_req_i),
    .load_ack_i    (load_ack_o),
    .store_valid_i (store_valid_o),
    .store_en_i    ((instr[6:0] == rv_isa_pkg::OPC_STORE) && run_i)
);

// File: tb/rv32i_tb.sv
module rv32i_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;

    localparam int PC_WIDTH = 10;
    localparam int DMEM_AW  = 8;
    // 5 programs, up to 64 words of ~4 cycles each, plus 200 run cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic arst_n;
    logic soft_rst_n;
    logic core_rst_n;
    logic run;
    logic load_req;
    logic [PC_WIDTH-3:0] load_addr;
    logic [31:0] load_data;
    logic load_ack;
    logic store_valid;
    logic [31:0] store_addr;
    logic [3:0] store_be;
    logic [31:0] store_data;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [3:0] exp_be [$];
    logic [31:0] exp_data [$];
    logic [31:0] model [int];   // data memory words by word address
    string test_name;
    int cycles = 0;
    int errors = 0;

    assign core_rst_n = arst_n && soft_rst_n;

    tb_clock_gen i_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    rv32i_core #(.PC_WIDTH(PC_WIDTH), .DMEM_AW(DMEM_AW)) i_dut (
        .clk_i         (clk),
        .arst_n_i      (core_rst_n),
        .run_i         (run),
        .load_req_i    (load_req),
        .load_addr_i   (load_addr),
        .load_data_i   (load_data),
        .load_ack_o    (load_ack),
        .store_valid_o (store_valid),
        .store_addr_o  (store_addr),
        .store_be_o    (store_be),
        .store_data_o  (store_data)
    );

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input int off, input logic [4:0] rs2,
                                           input logic [2:0] f3);
        return {off[11:5], rs2, 5'd0, f3, off[4:0], OPC_STORE}; // base is x0
    endfunction

    function automatic logic [31:0] b_type(input int off, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input int imm);
        return i_type(imm, rs1, F3_ADD, rd, OPC_OP_IMM);
    endfunction

    // load result as the RV32I width rules give it
    function automatic logic [31:0] load_ext(input logic [2:0] f3, input int addr);
        logic [31:0] w;
        w = model[addr >> 2] >> (8 * (addr & 3));
        case (f3)
            BYTE:    return {{24{w[7]}}, w[7:0]};
            HALF:    return {{16{w[15]}}, w[15:0]};
            BYTE_U:  return {24'd0, w[7:0]};
            HALF_U:  return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic stop_on_error();
        errors++;
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("%s: %s", test_name, what);
        stop_on_error();
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_be(input string what, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    // store instruction plus the report it must produce
    task automatic store_op(input logic [2:0] f3, input logic [4:0] rs2, input int addr,
                            input logic [31:0] val);
        logic [31:0] w;
        logic [3:0] be;
        int lane;
        lane = addr & 3;
        w = model.exists(addr >> 2) ? model[addr >> 2] : 32'd0;
        case (f3)
            BYTE: begin
                be = 4'b0001 << lane;
                w[8*lane +: 8] = val[7:0];
            end
            HALF: begin
                be = 4'b0011 << lane;
                w[8*lane +: 16] = val[15:0];
            end
            default: begin
                be = 4'b1111;
                w = val;
            end
        endcase
        model[addr >> 2] = w;
        prog.push_back(s_type(addr, rs2, f3));
        exp_addr.push_back(addr);
        exp_be.push_back(be);
        exp_data.push_back(w);
    endtask

    task automatic restart_core(input string name);
        test_name = name;
        prog.delete();
        exp_addr.delete();
        exp_be.delete();
        exp_data.delete();
        @(posedge clk);
        soft_rst_n <= 1'b0;
        run        <= 1'b0;
        @(posedge clk);
        soft_rst_n <= 1'b1;
        @(negedge clk);
    endtask

    // one four-phase write, entered and left at a falling edge
    task automatic load_word(input int idx);
        if (load_ack !== 1'b0) report_error("ack was high before a new request");
        @(posedge clk);
        load_req  <= 1'b1;
        load_addr <= idx[PC_WIDTH-3:0];
        load_data <= prog[idx];
        @(negedge clk);
        while (load_ack !== 1'b1) @(negedge clk);
        @(posedge clk);
        load_req <= 1'b0;
        @(negedge clk);
        if (load_ack !== 1'b1) report_error("ack dropped before the request fell");
        while (load_ack !== 1'b0) @(negedge clk);
    endtask

    task automatic run_program();
        for (int i = 0; i < prog.size(); i++) begin
            load_word(i);
        end
        @(posedge clk);
        run <= 1'b1;
        for (int k = 0; k < exp_addr.size(); k++) begin
            @(negedge clk);
            while (store_valid !== 1'b1) @(negedge clk);
            check_word("store address", exp_addr[k], store_addr);
            check_be("byte enables", exp_be[k], store_be);
            check_word("store data", exp_data[k], store_data);
        end
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
    endtask

    task automatic alu_case(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp);
        prog.push_back(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
        store_op(WORD, 5'd3, 'h100 + 4 * exp_addr.size(), exp);
    endtask

    task automatic test_alu();
        restart_core("alu");
        // x1 = -100, x2 = 6
        prog.push_back(addi(5'd1, 5'd0, -100));
        prog.push_back(addi(5'd2, 5'd0, 6));
        alu_case(7'h00, F3_ADD, 32'hffff_ffa2);  // -94
        alu_case(7'h20, F3_ADD, 32'hffff_ff96);  // -106
        alu_case(7'h00, F3_SLL, 32'hffff_e700);  // -6400
        alu_case(7'h00, F3_SLT, 32'd1);          // signed -100 < 6
        alu_case(7'h00, F3_SLTU, 32'd0);         // 0xffffff9c is large unsigned
        alu_case(7'h00, F3_XOR, 32'hffff_ff9a);
        alu_case(7'h00, F3_SR, 32'h03ff_fffe);   // zero fill
        alu_case(7'h20, F3_SR, 32'hffff_fffe);   // -100 / 64 rounded down
        alu_case(7'h00, F3_OR, 32'hffff_ff9e);
        alu_case(7'h00, F3_AND, 32'h0000_0004);
        prog.push_back(j_type(0, 5'd0)); // park
        run_program();
    endtask

    task automatic test_immediates();
        int pc;
        restart_core("immediates");
        prog.push_back({20'habcde, 5'd4, OPC_LUI});
        store_op(WORD, 5'd4, 'h140, 32'habcd_e000);
        pc = 4 * prog.size();
        prog.push_back({20'h12345, 5'd5, OPC_AUIPC});
        store_op(WORD, 5'd5, 'h144, 32'h1234_5000 + pc);
        prog.push_back(addi(5'd6, 5'd0, -1));
        store_op(WORD, 5'd6, 'h148, 32'hffff_ffff);
        prog.push_back(addi(5'd7, 5'd0, -2048));
        store_op(WORD, 5'd7, 'h14c, 32'hffff_f800);
        prog.push_back(i_type(-1, 5'd4, F3_XOR, 5'd8, OPC_OP_IMM));
        store_op(WORD, 5'd8, 'h150, 32'habcd_e000 ^ 32'hffff_ffff);
        prog.push_back(j_type(0, 5'd0));
        run_program();
    endtask

    // taken path stores 200+n, fall-through stores 100+n
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] ra, input logic [4:0] rb,
                               input logic taken);
        int n;
        n = exp_addr.size();
        prog.push_back(b_type(12, ra, rb, f3));
        prog.push_back(addi(5'd10, 5'd0, 100 + n));
        prog.push_back(j_type(8, 5'd0));
        prog.push_back(addi(5'd10, 5'd0, 200 + n));
        store_op(WORD, 5'd10, 'h200 + 4 * n, taken ? 32'(200 + n) : 32'(100 + n));
    endtask

    task automatic test_branches();
        int p;
        restart_core("branches");
        prog.push_back(addi(5'd1, 5'd0, -5));
        prog.push_back(addi(5'd2, 5'd0, 7));
        prog.push_back(addi(5'd3, 5'd0, 7));
        branch_case(BEQ, 5'd2, 5'd3, 1'b1);
        branch_case(BEQ, 5'd1, 5'd2, 1'b0);
        branch_case(BNE, 5'd1, 5'd2, 1'b1);
        branch_case(BNE, 5'd2, 5'd3, 1'b0);
        branch_case(BLT, 5'd1, 5'd2, 1'b1);
        branch_case(BLT, 5'd2, 5'd1, 1'b0);
        branch_case(BGE, 5'd2, 5'd1, 1'b1);
        branch_case(BGE, 5'd1, 5'd2, 1'b0);
        branch_case(BLTU, 5'd2, 5'd1, 1'b1);
        branch_case(BLTU, 5'd1, 5'd2, 1'b0);
        branch_case(BGEU, 5'd1, 5'd2, 1'b1);
        branch_case(BGEU, 5'd2, 5'd1, 1'b0);
        p = prog.size();
        prog.push_back(j_type(8, 5'd11));  // skips the clear
        prog.push_back(addi(5'd11, 5'd0, 0));
        store_op(WORD, 5'd11, 'h280, 32'(4 * p + 4));
        p = prog.size();
        prog.push_back(addi(5'd12, 5'd0, 4 * (p + 3) + 1)); // odd target
        prog.push_back(i_type(0, 5'd12, 3'b000, 5'd13, OPC_JALR));
        prog.push_back(addi(5'd13, 5'd0, 0));
        store_op(WORD, 5'd13, 'h284, 32'(4 * (p + 2)));
        prog.push_back(j_type(0, 5'd0));
        run_program();
    endtask

    task automatic load_case(input logic [2:0] f3, input int addr);
        prog.push_back(i_type(addr, 5'd0, f3, 5'd5, OPC_LOAD));
        store_op(WORD, 5'd5, 'h340 + 4 * exp_addr.size(), load_ext(f3, addr));
    endtask

    task automatic test_load_store();
        logic [31:0] x1_val;
        logic [31:0] x2_val;
        x1_val = 32'h1122_3344;
        x2_val = 32'hffff_ffa5;
        restart_core("load_store");
        prog.push_back({20'h11223, 5'd1, OPC_LUI});
        prog.push_back(addi(5'd1, 5'd1, 'h344));
        prog.push_back(addi(5'd2, 5'd0, -91));
        store_op(WORD, 5'd1, 'h300, x1_val);
        for (int lane = 0; lane < 4; lane++) begin
            store_op(BYTE, 5'd2, 'h300 + lane, x2_val);
        end
        store_op(WORD, 5'd1, 'h304, x1_val);
        store_op(HALF, 5'd2, 'h304, x2_val);
        store_op(WORD, 5'd1, 'h308, x1_val);
        store_op(HALF, 5'd2, 'h30a, x2_val);
        load_case(BYTE, 'h304);
        load_case(BYTE_U, 'h304);
        load_case(HALF, 'h304);
        load_case(HALF_U, 'h304);
        load_case(BYTE, 'h306);
        load_case(HALF, 'h306);
        load_case(BYTE_U, 'h30b);
        load_case(WORD, 'h308);
        prog.push_back(j_type(0, 5'd0));
        run_program();
    endtask

    task automatic test_x0();
        restart_core("x0");
        prog.push_back(addi(5'd0, 5'd0, 55));
        store_op(WORD, 5'd0, 'h380, 32'd0);
        prog.push_back(addi(5'd1, 5'd0, 9));
        prog.push_back(r_type(7'h00, 5'd1, 5'd1, F3_ADD, 5'd0));
        store_op(WORD, 5'd0, 'h384, 32'd0);
        prog.push_back({20'hfffff, 5'd0, OPC_LUI});
        store_op(WORD, 5'd0, 'h388, 32'd0);
        store_op(WORD, 5'd1, 'h38c, 32'd9);
        prog.push_back(j_type(0, 5'd0));
        run_program();
    endtask

    // per-request ack checks sit in load_word and run in every test
    task automatic test_loader_reset();
        test_name = "loader";
        if (load_ack !== 1'b0) report_error("load_ack_o was not low after reset");
        if (store_valid !== 1'b0) report_error("store_valid_o was not low after reset");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        soft_rst_n = 1'b1;
        run        = 1'b0;
        load_req   = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        test_loader_reset();
        test_alu();
        test_immediates();
        test_branches();
        test_load_store();
        test_x0();
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// File: verilog/rv32i_core.sv
module rv32i_core #(
    parameter int PC_WIDTH = 10,
    parameter int DMEM_AW  = 8
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                run_i,
    input  logic                load_req_i,
    input  logic [PC_WIDTH-3:0] load_addr_i,
    input  logic [31:0]         load_data_i,
    output logic                load_ack_o,
    output logic                store_valid_o,
    output logic [31:0]         store_addr_o,
    output logic [3:0]          store_be_o,
    output logic [31:0]         store_data_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] pc_next;
    logic [31:0] pc_ext;
    logic [31:0] pc_plus4;

    logic [31:0] instr;
    alu_op_t alu_op;
    funct3_t funct3;
    src1_t src1;
    src2_t src2;
    srcr_t srcr;
    next_pc_t pc_control;
    logic [4:0] rs1, rs2, rd;
    logic [31:0] imm;
    logic reg_write, mem_read, mem_write;

    logic [31:0] rs1_data, rs2_data;
    logic [31:0] alu_a, alu_b;
    logic [31:0] alu_result;
    logic take_branch;
    logic [31:0] load_data;
    logic [31:0] wb_data;

    assign pc_ext   = {{(32-PC_WIDTH){1'b0}}, pc};
    assign pc_plus4 = pc_ext + 32'd4;

    always_comb begin
        if (pc_control == JUMP) begin
            pc_next = alu_result[PC_WIDTH-1:0] & ~PC_WIDTH'(1); // JALR clears bit 0
        end else if (take_branch) begin
            pc_next = alu_result[PC_WIDTH-1:0];
        end else begin
            pc_next = pc_plus4[PC_WIDTH-1:0];
        end
    end

    // pc only moves while running
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else if (run_i) begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (src1)
            RS1:     alu_a = rs1_data;
            PC:      alu_a = pc_ext;
            default: alu_a = '0; // ZERO
        endcase
    end

    assign alu_b   = (src2 == IMM) ? imm : rs2_data;
    assign wb_data = (srcr == NEXT_PC) ? pc_plus4 : (mem_read ? load_data : alu_result);

    rv_imem_loader #(.PC_WIDTH(PC_WIDTH)) u_imem (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .load_req_i  (load_req_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .load_ack_o  (load_ack_o),
        .fetch_pc_i  (pc),
        .instr_o     (instr)
    );

    rv_decoder u_decoder (
        .instr_i      (instr),
        .alu_op_o     (alu_op),
        .funct3_o     (funct3),
        .src1_o       (src1),
        .src2_o       (src2),
        .srcr_o       (srcr),
        .pc_control_o (pc_control),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rd_o         (rd),
        .imm_o        (imm),
        .reg_write_o  (reg_write),
        .mem_read_o   (mem_read),
        .mem_write_o  (mem_write)
    );

    rv_reg_file u_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ra1_i    (rs1),
        .ra2_i    (rs2),
        .wa_i     (rd),
        .we_i     (reg_write && run_i), // no side effects while stopped
        .wd_i     (wb_data),
        .rd1_o    (rs1_data),
        .rd2_o    (rs2_data)
    );

    rv_execute u_execute (
        .a_i           (alu_a),
        .b_i           (alu_b),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .alu_op_i      (alu_op),
        .funct3_i      (funct3),
        .pc_control_i  (pc_control),
        .result_o      (alu_result),
        .take_branch_o (take_branch)
    );

    rv_data_mem #(.DMEM_AW(DMEM_AW)) u_dmem (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .addr_i        (alu_result),
        .wdata_i       (rs2_data),
        .funct3_i      (funct3),
        .read_i        (mem_read),
        .write_i       (mem_write && run_i),
        .rdata_o       (load_data),
        .store_valid_o (store_valid_o),
        .store_addr_o  (store_addr_o),
        .store_be_o    (store_be_o),
        .store_data_o  (store_data_o)
    );

endmodule

// File: verilog/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // alu operand 1
    typedef enum logic [1:0] {
        RS1  = 2'd0,
        ZERO = 2'd1,
        PC   = 2'd2
    } src1_t;

    // alu operand 2
    typedef enum logic {
        RS2 = 1'b0,
        IMM = 1'b1
    } src2_t;

    // write-back source
    typedef enum logic {
        RESULT  = 1'b0,
        NEXT_PC = 1'b1  // link value for jumps
    } srcr_t;

    typedef enum logic [1:0] {
        SEQ    = 2'd0,
        BRANCH = 2'd1,
        JUMP   = 2'd2
    } next_pc_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND,
        ALU_PASS_B  // used by LUI
    } alu_op_t;

endpackage

// File: verilog/rv_data_mem.sv
module rv_data_mem #(
    parameter int DMEM_AW = 8
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic [31:0]         addr_i,
    input  logic [31:0]         wdata_i,
    input  rv_isa_pkg::funct3_t funct3_i,
    input  logic                read_i,
    input  logic                write_i,
    output logic [31:0]         rdata_o,
    output logic                store_valid_o,
    output logic [31:0]         store_addr_o,
    output logic [3:0]          store_be_o,
    output logic [31:0]         store_data_o
);
    import rv_isa_pkg::*;

    logic [31:0] mem [2**DMEM_AW];
    logic [DMEM_AW-1:0] word_addr;
    logic [1:0] lane;
    logic [31:0] cur_word;
    logic [31:0] shifted;    // addressed lane moved down to bit 0
    logic [31:0] wlanes;     // store data replicated over the lanes
    logic [3:0] be;
    logic [31:0] merged;
    logic [31:0] load_val;

    assign word_addr = addr_i[DMEM_AW+1:2];
    assign lane      = addr_i[1:0];
    assign cur_word  = mem[word_addr];

    always_comb begin
        case (funct3_i)
            BYTE: begin
                be     = 4'b0001 << lane;
                wlanes = {4{wdata_i[7:0]}};
            end
            HALF: begin
                be     = 4'b0011 << {lane[1], 1'b0};
                wlanes = {2{wdata_i[15:0]}};
            end
            default: begin
                be     = 4'b1111;
                wlanes = wdata_i;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = be[i] ? wlanes[8*i +: 8] : cur_word[8*i +: 8];
        end
    end

    assign shifted = cur_word >> {lane, 3'b000};

    always_comb begin
        case (funct3_i)
            BYTE:    load_val = {{24{shifted[7]}}, shifted[7:0]};
            HALF:    load_val = {{16{shifted[15]}}, shifted[15:0]};
            BYTE_U:  load_val = {24'b0, shifted[7:0]};
            HALF_U:  load_val = {16'b0, shifted[15:0]};
            default: load_val = cur_word;
        endcase
    end

    assign rdata_o = read_i ? load_val : '0;

    // word write and store report payload
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            mem[word_addr] <= merged;
            store_addr_o   <= addr_i;
            store_be_o     <= be;
            store_data_o   <= merged; // whole word after the merge
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            store_valid_o <= 1'b0;
        end else begin
            store_valid_o <= write_i; // one cycle per store
        end
    end

endmodule

// File: verilog/rv_decoder.sv
module rv_decoder (
    input  logic [31:0]           instr_i,
    output rv_ctrl_pkg::alu_op_t  alu_op_o,
    output rv_isa_pkg::funct3_t   funct3_o,
    output rv_ctrl_pkg::src1_t    src1_o,
    output rv_ctrl_pkg::src2_t    src2_o,
    output rv_ctrl_pkg::srcr_t    srcr_o,
    output rv_ctrl_pkg::next_pc_t pc_control_o,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output logic [4:0]            rd_o,
    output logic [31:0]           imm_o,
    output logic                  reg_write_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_t opcode;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    // funct3 plus funct7[5] to an alu operation
    function automatic alu_op_t alu_op_from(input funct3_t f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode   = opcode_t'(instr_i[6:0]);
    assign funct3_o = instr_i[14:12];
    assign rd_o     = instr_i[11:7];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        // unknown opcodes fall through as a no-op
        alu_op_o     = ALU_ADD;
        src1_o       = RS1;
        src2_o       = RS2;
        srcr_o       = RESULT;
        pc_control_o = SEQ;
        imm_o        = '0;
        reg_write_o  = 1'b0;
        mem_read_o   = 1'b0;
        mem_write_o  = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o    = alu_op_from(funct3_o, instr_i[30]);
                reg_write_o = 1'b1;
            end
            OPC_OP_IMM: begin
                // bit 30 is immediate data except for shifts right
                alu_op_o    = alu_op_from(funct3_o, (funct3_o == F3_SR) && instr_i[30]);
                src2_o      = IMM;
                imm_o       = imm_i;
                reg_write_o = 1'b1;
            end
            OPC_LOAD: begin
                src2_o      = IMM;
                imm_o       = imm_i;
                mem_read_o  = 1'b1;
                reg_write_o = 1'b1;
            end
            OPC_STORE: begin
                src2_o      = IMM;
                imm_o       = imm_s;
                mem_write_o = 1'b1;
            end
            OPC_BRANCH: begin
                src1_o       = PC; // alu builds the target
                src2_o       = IMM;
                imm_o        = imm_b;
                pc_control_o = BRANCH;
            end
            OPC_JAL: begin
                src1_o       = PC;
                src2_o       = IMM;
                imm_o        = imm_j;
                srcr_o       = NEXT_PC;
                pc_control_o = JUMP;
                reg_write_o  = 1'b1;
            end
            OPC_JALR: begin
                src2_o       = IMM;
                imm_o        = imm_i;
                srcr_o       = NEXT_PC;
                pc_control_o = JUMP;
                reg_write_o  = 1'b1;
            end
            OPC_LUI: begin
                alu_op_o    = ALU_PASS_B;
                src1_o      = ZERO;
                src2_o      = IMM;
                imm_o       = imm_u;
                reg_write_o = 1'b1;
            end
            OPC_AUIPC: begin
                src1_o      = PC;
                src2_o      = IMM;
                imm_o       = imm_u;
                reg_write_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/rv_execute.sv
module rv_execute (
    input  logic [31:0]           a_i,
    input  logic [31:0]           b_i,
    input  logic [31:0]           rs1_data_i,
    input  logic [31:0]           rs2_data_i,
    input  rv_ctrl_pkg::alu_op_t  alu_op_i,
    input  rv_isa_pkg::funct3_t   funct3_i,
    input  rv_ctrl_pkg::next_pc_t pc_control_i,
    output logic [31:0]           result_o,
    output logic                  take_branch_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [4:0] shamt;
    logic eq, lt, ltu;
    logic cond;

    assign shamt = b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU:   result_o = {31'b0, a_i < b_i};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

    // branch compare works on the register values, not the alu operands
    assign eq  = rs1_data_i == rs2_data_i;
    assign lt  = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign ltu = rs1_data_i < rs2_data_i;

    always_comb begin
        case (funct3_i)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt;
            BGE:     cond = !lt;
            BLTU:    cond = ltu;
            BGEU:    cond = !ltu;
            default: cond = 1'b0; // 010, 011 are not branches
        endcase
    end

    assign take_branch_o = (pc_control_i == BRANCH) && cond;

endmodule

// File: verilog/rv_imem_loader.sv
module rv_imem_loader #(
    parameter int PC_WIDTH = 10
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                load_req_i,
    input  logic [PC_WIDTH-3:0] load_addr_i,
    input  logic [31:0]         load_data_i,
    output logic                load_ack_o,
    input  logic [PC_WIDTH-1:0] fetch_pc_i,
    output logic [31:0]         instr_o
);

    localparam int WORDS = 2**(PC_WIDTH-2);

    logic [31:0] imem [WORDS];
    logic write_en;

    // ack low means the request has not been served yet
    assign write_en = load_req_i && !load_ack_o;

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            imem[load_addr_i] <= load_data_i;
        end
    end

    // ack follows req one edge later, rise and fall alike
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            load_ack_o <= 1'b0;
        end else if (write_en) begin
            load_ack_o <= 1'b1;
        end else if (!load_req_i) begin
            load_ack_o <= 1'b0;
        end
    end

    // word fetch, low pc bits ignored
    assign instr_o = imem[fetch_pc_i[PC_WIDTH-1:2]];

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    // meaning depends on the opcode
    typedef logic [2:0] funct3_t;

    // alu variants (OP, OP_IMM)
    localparam funct3_t F3_ADD  = 3'b000; // also SUB with funct7[5]
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // SRL / SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branch conditions
    localparam funct3_t BEQ  = 3'b000;
    localparam funct3_t BNE  = 3'b001;
    localparam funct3_t BLT  = 3'b100;
    localparam funct3_t BGE  = 3'b101;
    localparam funct3_t BLTU = 3'b110;
    localparam funct3_t BGEU = 3'b111;

    // load and store widths
    localparam funct3_t BYTE   = 3'b000;
    localparam funct3_t HALF   = 3'b001;
    localparam funct3_t WORD   = 3'b010;
    localparam funct3_t BYTE_U = 3'b100;
    localparam funct3_t HALF_U = 3'b101;

endpackage

// File: verilog/rv_reg_file.sv
module rv_reg_file (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [4:0]                    ra1_i,
    input  logic [4:0]                    ra2_i,
    input  logic [4:0]                    wa_i,
    input  logic                          we_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   wd_i,
    output logic [rv_isa_pkg::XLEN-1:0]   rd1_o,
    output logic [rv_isa_pkg::XLEN-1:0]   rd2_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != 5'd0)) begin
            regs[wa_i] <= wd_i; // x0 writes dropped
        end
    end

    // x0 always reads zero
    assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

endmodule
